// File: Bender.yml
package:
  name: ball_imgproc

sources:
  - logic/ball_imgproc_pkg.sv
  - logic/stream_reg.sv
  - logic/hsv_convert.sv
  - logic/ball_detector.sv
  - logic/box_tracker.sv
  - logic/pixel_overlay.sv
  - logic/msg_port.sv
  - logic/ball_imgproc.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_ball_imgproc.sv

// File: ball_imgproc.f
logic/ball_imgproc_pkg.sv
logic/stream_reg.sv
logic/hsv_convert.sv
logic/ball_detector.sv
logic/box_tracker.sv
logic/pixel_overlay.sv
logic/msg_port.sv
logic/ball_imgproc.sv
tests/tb_clock.sv
tests/tb_ball_imgproc.sv

// File: logic/ball_detector.sv
//////////////////////////////////////////////////////////////////////
// ball colour detection and run filter
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ball_detector import ball_imgproc_pkg::*; (
	input  logic       clk,
	input  logic       reset_n,
	input  logic       advance,
	input  logic       sop,
	input  logic       packet_video,
	input  hsv_t       hsv,
	output ball_mask_t raw,
	output ball_mask_t confirmed
);

	typedef logic [$clog2(RUN_LEN)-1:0] run_cnt_t;

	run_cnt_t run_cnt [4];

	function automatic logic in_window(hsv_t p, hsv_window_t w);
		return (p.hue >= w.hue_lo) && (p.hue <= w.hue_hi) &&
			(p.sat >= w.sat_lo) && (p.sat <= w.sat_hi) &&
			(p.val >= w.val_lo) && (p.val <= w.val_hi);
	endfunction

	assign raw[0] = in_window(hsv, RED_WIN);
	assign raw[1] = in_window(hsv, YELLOW_WIN);
	assign raw[2] = in_window(hsv, TEAL_WIN_A) | in_window(hsv, TEAL_WIN_B);
	assign raw[3] = in_window(hsv, PINK_WIN_A) | in_window(hsv, PINK_WIN_B);

	// counter holds how many of the previous pixels matched in a row
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < 4; i++)
				run_cnt[i] <= '0;
		end else if (advance) begin
			for (int i = 0; i < 4; i++) begin
				if (sop || !raw[i])
					run_cnt[i] <= '0;
				else if (run_cnt[i] != run_cnt_t'(RUN_LEN - 1))
					run_cnt[i] <= run_cnt[i] + 1'b1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < 4; i++)
			confirmed[i] = packet_video & ~sop & raw[i] &
				(run_cnt[i] == run_cnt_t'(RUN_LEN - 1));
	end

endmodule

// File: logic/ball_imgproc.sv
//////////////////////////////////////////////////////////////////////
// ball detection video block
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ball_imgproc import ball_imgproc_pkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        mode,
	// stream in
	input  logic [23:0] sink_data,
	input  logic        sink_valid,
	output logic        sink_ready,
	input  logic        sink_sop,
	input  logic        sink_eop,
	// stream out
	output logic [23:0] source_data,
	output logic        source_valid,
	input  logic        source_ready,
	output logic        source_sop,
	output logic        source_eop,
	// cpu registers
	input  logic        s_chipselect,
	input  logic        s_read,
	input  logic        s_write,
	input  logic [2:0]  s_address,
	input  logic [31:0] s_writedata,
	output logic [31:0] s_readdata
);

	beat_t sink_beat, cur_beat, ovl_beat, source_beat;
	logic cur_valid, out_ready, advance, packet_video, fifo_room, msg_start;
	hsv_t hsv;
	ball_mask_t confirmed;
	coord_t x;
	box_set_t boxes;

	assign sink_beat = {sink_data, sink_sop, sink_eop};
	assign source_data = source_beat.pixel;
	assign source_sop = source_beat.sop;
	assign source_eop = source_beat.eop;
	// per-pixel state moves only when the current beat leaves
	assign advance = cur_valid & out_ready;

	stream_reg in_reg (
		.clk(clk), .reset_n(reset_n),
		.in_valid(sink_valid), .in_beat(sink_beat), .in_ready(sink_ready),
		.out_valid(cur_valid), .out_beat(cur_beat), .out_ready(out_ready)
	);

	hsv_convert hsv_conv (.pixel(cur_beat.pixel), .hsv(hsv));

	ball_detector detector (
		.clk(clk), .reset_n(reset_n), .advance(advance), .sop(cur_beat.sop),
		.packet_video(packet_video), .hsv(hsv), .raw(), .confirmed(confirmed)
	);

	box_tracker tracker (
		.clk(clk), .reset_n(reset_n), .advance(advance), .sop(cur_beat.sop),
		.eop(cur_beat.eop), .sop_blue_low(cur_beat.pixel.blue[3:0]),
		.confirmed(confirmed), .fifo_room(fifo_room), .x(x),
		.packet_video(packet_video), .boxes(boxes), .msg_start(msg_start)
	);

	pixel_overlay overlay (
		.mode(mode), .packet_video(packet_video), .in_beat(cur_beat), .x(x),
		.boxes(boxes), .confirmed(confirmed), .out_beat(ovl_beat)
	);

	stream_reg out_reg (
		.clk(clk), .reset_n(reset_n),
		.in_valid(cur_valid), .in_beat(ovl_beat), .in_ready(out_ready),
		.out_valid(source_valid), .out_beat(source_beat), .out_ready(source_ready)
	);

	msg_port msg (
		.clk(clk), .reset_n(reset_n), .msg_start(msg_start), .boxes(boxes),
		.fifo_room(fifo_room), .s_chipselect(s_chipselect), .s_read(s_read),
		.s_write(s_write), .s_address(s_address), .s_writedata(s_writedata),
		.s_readdata(s_readdata)
	);

endmodule

// File: logic/ball_imgproc_pkg.sv
//////////////////////////////////////////////////////////////////////
// ball detection shared definitions
//////////////////////////////////////////////////////////////////////
package ball_imgproc_pkg;

	typedef logic [7:0] channel_t;
	typedef logic [10:0] coord_t;
	typedef logic [3:0] ball_mask_t;
	typedef logic [8:0] fifo_count_t;

	typedef struct packed {
		channel_t red;
		channel_t green;
		channel_t blue;
	} rgb_t;

	typedef struct packed {
		logic [7:0] hue;
		logic [7:0] sat;
		logic [7:0] val;
	} hsv_t;

	// one stream beat, same bit order as the pins
	typedef struct packed {
		rgb_t pixel;
		logic sop;
		logic eop;
	} beat_t;

	typedef struct packed {
		coord_t left;
		coord_t right;
	} box_t;

	// index 0 red, 1 yellow, 2 teal, 3 pink
	typedef box_t [3:0] box_set_t;

	typedef enum logic [2:0] {
		MSG_IDLE,
		MSG_HEADER,
		MSG_RED,
		MSG_YELLOW,
		MSG_TEAL,
		MSG_PINK
	} msg_state_e;

	// inclusive limits on each hsv component
	typedef struct packed {
		logic [7:0] hue_lo;
		logic [7:0] hue_hi;
		logic [7:0] sat_lo;
		logic [7:0] sat_hi;
		logic [7:0] val_lo;
		logic [7:0] val_hi;
	} hsv_window_t;

	//////////////////////////////////////////////////////////////////////
	// image and message constants
	//////////////////////////////////////////////////////////////////////
	localparam int IMAGE_W = 640;
	localparam int RUN_LEN = 10;
	localparam int MSG_INTERVAL = 6;
	localparam int MSG_FIFO_DEPTH = 256;
	localparam int MSG_WORDS = 5;
	localparam logic [31:0] MSG_ID = {8'h00, "RBB"};
	localparam logic [31:0] CORE_ID = 32'h1234EEE2;

	localparam logic [2:0] REG_STATUS = 3'd0;
	localparam logic [2:0] REG_MSG = 3'd1;
	localparam logic [2:0] REG_ID = 3'd2;
	localparam int STATUS_FLUSH_BIT = 4;

	// no detection yet in this frame
	localparam box_t EMPTY_BOX = '{left: coord_t'(IMAGE_W - 1), right: coord_t'(0)};

	localparam rgb_t [3:0] FILL_COLOUR = {24'hdf55e2, 24'h008080, 24'hffff00, 24'hff1000};
	localparam rgb_t [3:0] EDGE_COLOUR = {24'hffc0cb, 24'h008080, 24'hffff00, 24'hff0000};
	localparam logic [3:0][3:0] COLOUR_ID = {4'd4, 4'd3, 4'd2, 4'd1};

	//////////////////////////////////////////////////////////////////////
	// thresholds, ordered hue, sat, val as lo/hi pairs
	//////////////////////////////////////////////////////////////////////
	localparam hsv_window_t RED_WIN = '{8'd7, 8'd12, 8'd220, 8'd255, 8'd75, 8'd189};
	localparam hsv_window_t YELLOW_WIN = '{8'd24, 8'd31, 8'd179, 8'd214, 8'd244, 8'd255};
	localparam hsv_window_t TEAL_WIN_A = '{8'd69, 8'd85, 8'd101, 8'd199, 8'd111, 8'd244};
	localparam hsv_window_t TEAL_WIN_B = '{8'd69, 8'd80, 8'd81, 8'd113, 8'd61, 8'd255};
	localparam hsv_window_t PINK_WIN_A = '{8'd2, 8'd12, 8'd100, 8'd184, 8'd248, 8'd255};
	localparam hsv_window_t PINK_WIN_B = '{8'd1, 8'd8, 8'd100, 8'd203, 8'd189, 8'd255};

endpackage

// File: logic/box_tracker.sv
//////////////////////////////////////////////////////////////////////
// pixel position and bounding box tracking
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module box_tracker import ball_imgproc_pkg::*; (
	input  logic       clk,
	input  logic       reset_n,
	input  logic       advance,
	input  logic       sop,
	input  logic       eop,
	input  logic [3:0] sop_blue_low,
	input  ball_mask_t confirmed,
	input  logic       fifo_room,
	output coord_t     x,
	output logic       packet_video,
	output box_set_t   boxes,
	output logic       msg_start
);

	typedef logic [$clog2(MSG_INTERVAL)-1:0] frame_cnt_t;

	box_set_t bounds, bounds_next;
	frame_cnt_t frame_cnt;
	logic video_eop;

	assign video_eop = advance & eop & ~sop & packet_video;

	// column count restarts with every descriptor
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x <= '0;
			packet_video <= 1'b0;
		end else if (advance) begin
			if (sop) begin
				x <= '0;
				packet_video <= (sop_blue_low == 4'h0);
			end else if (x == coord_t'(IMAGE_W - 1)) begin
				x <= '0;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	// widen this frame's bounds with the current pixel
	always_comb begin
		bounds_next = bounds;
		for (int i = 0; i < 4; i++) begin
			if (sop) begin
				bounds_next[i] = EMPTY_BOX;
			end else if (confirmed[i]) begin
				if (x < bounds[i].left)
					bounds_next[i].left = x;
				if (x > bounds[i].right)
					bounds_next[i].right = x;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			bounds <= {4{EMPTY_BOX}};
			boxes <= {4{EMPTY_BOX}};
		end else if (advance) begin
			bounds <= bounds_next;
			if (video_eop)
				boxes <= bounds_next;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// message interval
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			frame_cnt <= '0;
			msg_start <= 1'b0;
		end else begin
			msg_start <= 1'b0;
			if (video_eop) begin
				if (frame_cnt != '0) begin
					frame_cnt <= frame_cnt - 1'b1;
				end else if (fifo_room) begin
					msg_start <= 1'b1;
					frame_cnt <= frame_cnt_t'(MSG_INTERVAL - 1);
				end
			end
		end
	end

endmodule

// File: logic/hsv_convert.sv
//////////////////////////////////////////////////////////////////////
// rgb to hsv conversion
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module hsv_convert import ball_imgproc_pkg::*; (
	input  rgb_t pixel,
	output hsv_t hsv
);

	logic [7:0] max_c, min_c;
	logic [31:0] r, g, b, delta, sat_full, hue_deg;

	always_comb begin
		r = 32'(pixel.red);
		g = 32'(pixel.green);
		b = 32'(pixel.blue);
		max_c = (r > g) ? ((r > b) ? pixel.red : pixel.blue) : ((g > b) ? pixel.green : pixel.blue);
		min_c = (r < g) ? ((r < b) ? pixel.red : pixel.blue) : ((g < b) ? pixel.green : pixel.blue);
		delta = 32'(max_c) - 32'(min_c);
		sat_full = (max_c == 8'd0) ? 32'd0 : (delta * 32'd255) / 32'(max_c);

		// hexcone hue in degrees, unsigned wrap cancels in the division
		if (delta == 32'd0) begin
			hue_deg = 32'd0;
		end else if (max_c != pixel.red) begin
			if (max_c != pixel.green)
				hue_deg = (32'd240 * delta + 32'd60 * (r - g)) / delta;
			else
				hue_deg = (32'd120 * delta + 32'd60 * (b - r)) / delta;
		end else if (b < g) begin
			hue_deg = (32'd60 * (g - b)) / delta;
		end else begin
			hue_deg = (32'd360 * delta + 32'd60 * (g - b)) / delta;
		end

		hsv.hue = 8'(hue_deg >> 1);
		hsv.sat = 8'(sat_full);
		hsv.val = max_c;
	end

endmodule

// File: logic/msg_port.sv
//////////////////////////////////////////////////////////////////////
// message FIFO and register port
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module msg_port import ball_imgproc_pkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        msg_start,
	input  box_set_t    boxes,
	output logic        fifo_room,
	input  logic        s_chipselect,
	input  logic        s_read,
	input  logic        s_write,
	input  logic [2:0]  s_address,
	input  logic [31:0] s_writedata,
	output logic [31:0] s_readdata
);

	typedef logic [$clog2(MSG_FIFO_DEPTH)-1:0] ptr_t;

	msg_state_e state;
	logic [31:0] fifo_mem [MSG_FIFO_DEPTH];
	ptr_t wr_ptr, rd_ptr;
	fifo_count_t count;
	logic [31:0] wr_word, head;
	logic wr_en, rd_en, flush, read_d;

	function automatic logic [31:0] box_word(logic [3:0] id, box_t box);
		return {id, 6'b0, box.left, box.right};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// message writer
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= MSG_IDLE;
		end else begin
			case (state)
				MSG_IDLE:   if (msg_start) state <= MSG_HEADER;
				MSG_HEADER: state <= MSG_RED;
				MSG_RED:    state <= MSG_YELLOW;
				MSG_YELLOW: state <= MSG_TEAL;
				MSG_TEAL:   state <= MSG_PINK;
				default:    state <= MSG_IDLE;
			endcase
		end
	end

	always_comb begin
		case (state)
			MSG_HEADER: wr_word = MSG_ID;
			MSG_RED:    wr_word = box_word(COLOUR_ID[0], boxes[0]);
			MSG_YELLOW: wr_word = box_word(COLOUR_ID[1], boxes[1]);
			MSG_TEAL:   wr_word = box_word(COLOUR_ID[2], boxes[2]);
			MSG_PINK:   wr_word = box_word(COLOUR_ID[3], boxes[3]);
			default:    wr_word = 32'd0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// show-ahead FIFO
	//////////////////////////////////////////////////////////////////////
	assign head = fifo_mem[rd_ptr];
	assign wr_en = (state != MSG_IDLE) && (count != fifo_count_t'(MSG_FIFO_DEPTH));
	// pop only on the first cycle of a read strobe
	assign rd_en = s_chipselect & s_read & ~read_d & (s_address == REG_MSG) & (count != '0);
	assign flush = s_chipselect & s_write & (s_address == REG_STATUS) &
		s_writedata[STATUS_FLUSH_BIT];
	assign fifo_room = (count <= fifo_count_t'(MSG_FIFO_DEPTH - MSG_WORDS));

	always_ff @(posedge clk) begin
		if (wr_en)
			fifo_mem[wr_ptr] <= wr_word;
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

	// register reads
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			s_readdata <= 32'd0;
			read_d <= 1'b0;
		end else begin
			read_d <= s_chipselect & s_read;
			if (s_chipselect && s_read) begin
				case (s_address)
					REG_STATUS: s_readdata <= {15'd0, count, 8'd0};
					REG_MSG:    s_readdata <= (count == '0) ? 32'd0 : head;
					REG_ID:     s_readdata <= CORE_ID;
					default:    s_readdata <= 32'd0;
				endcase
			end
		end
	end

endmodule

// File: logic/pixel_overlay.sv
//////////////////////////////////////////////////////////////////////
// output pixel overlay
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pixel_overlay import ball_imgproc_pkg::*; (
	input  logic       mode,
	input  logic       packet_video,
	input  beat_t      in_beat,
	input  coord_t     x,
	input  box_set_t   boxes,
	input  ball_mask_t confirmed,
	output beat_t      out_beat
);

	channel_t grey;
	rgb_t painted;

	// grey = green/2 + red/4 + blue/4
	assign grey = in_beat.pixel.green[7:1] + in_beat.pixel.red[7:2] + in_beat.pixel.blue[7:2];

	always_comb begin
		painted = '{red: grey, green: grey, blue: grey};
		// walk down so the lowest confirmed colour wins the fill
		for (int i = 3; i >= 0; i--)
			if (confirmed[i])
				painted = FILL_COLOUR[i];
		// walk up so the highest colour wins the edge
		for (int i = 0; i < 4; i++)
			if ((x == boxes[i].left && boxes[i].left != coord_t'(IMAGE_W - 1)) ||
				(x == boxes[i].right && boxes[i].right != coord_t'(0)))
				painted = EDGE_COLOUR[i];

		out_beat = in_beat;
		if (mode && packet_video && !in_beat.sop)
			out_beat.pixel = painted;
	end

endmodule

// File: logic/stream_reg.sv
//////////////////////////////////////////////////////////////////////
// stream pipeline register
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module stream_reg import ball_imgproc_pkg::*; (
	input  logic  clk,
	input  logic  reset_n,
	input  logic  in_valid,
	input  beat_t in_beat,
	output logic  in_ready,
	output logic  out_valid,
	output beat_t out_beat,
	input  logic  out_ready
);

	// accept when empty or when the held beat leaves this cycle
	assign in_ready = ~out_valid | out_ready;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_ready) begin
			out_beat <= in_beat;
		end
	end

endmodule

// File: tests/tb_ball_imgproc.sv
//////////////////////////////////////////////////////////////////////
// ball detection video block testbench
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_ball_imgproc import ball_imgproc_pkg::*; ();

	localparam int FRAME_ROWS = 4;
	localparam int FRAME_PIX = FRAME_ROWS * IMAGE_W;
	localparam int FRAME_BEATS = FRAME_PIX + 1;
	localparam int WATCHDOG_CYCLES = 12 * FRAME_BEATS * 4;
	localparam int NV_PIX = 64;
	localparam int RUN_ROW = 1;
	localparam int RED_START = 100;
	localparam int RED_END = 139;
	localparam int YELLOW_START = 300;
	localparam int YELLOW_END = 329;

	logic clk, reset_n, mode;
	logic [23:0] sink_data, source_data;
	logic sink_valid, sink_ready, sink_sop, sink_eop;
	logic source_valid, source_ready, source_sop, source_eop;
	logic s_chipselect, s_read, s_write;
	logic [2:0] s_address;
	logic [31:0] s_writedata, s_readdata;

	integer seed = 32'hd66d27e8;
	rgb_t pkt_pix [FRAME_PIX];
	beat_t exp_q [$];
	beat_t out_q [$];
	// boxes latched at the last video eop, and bounds of the packet in flight
	int box_left [4], box_right [4], cur_left [4], cur_right [4], run_len [4];

	tb_clock clock_gen (.clk(clk), .reset_n(reset_n));

	ball_imgproc ball_imgproc_i (.*);

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////
	function automatic hsv_t to_hsv(rgb_t p);
		int r, g, b, hi, lo, span, deg;
		hsv_t v;
		r = p.red;
		g = p.green;
		b = p.blue;
		hi = (r > g) ? r : g;
		if (b > hi)
			hi = b;
		lo = (r < g) ? r : g;
		if (b < lo)
			lo = b;
		span = hi - lo;
		if (span == 0)
			deg = 0;
		else if (hi == r)
			deg = (g > b) ? (60 * (g - b)) / span : (360 * span - 60 * (b - g)) / span;
		else if (hi == g)
			deg = (120 * span + 60 * (b - r)) / span;
		else
			deg = (240 * span + 60 * (r - g)) / span;
		v.hue = 8'(deg / 2);
		v.sat = (hi == 0) ? 8'd0 : 8'((span * 255) / hi);
		v.val = 8'(hi);
		return v;
	endfunction

	function automatic logic inside_window(hsv_t v, hsv_window_t w);
		return !(v.hue < w.hue_lo || v.hue > w.hue_hi || v.sat < w.sat_lo ||
			v.sat > w.sat_hi || v.val < w.val_lo || v.val > w.val_hi);
	endfunction

	function automatic ball_mask_t colour_match(rgb_t p);
		hsv_t v;
		ball_mask_t m;
		v = to_hsv(p);
		m[0] = inside_window(v, RED_WIN);
		m[1] = inside_window(v, YELLOW_WIN);
		m[2] = inside_window(v, TEAL_WIN_A) || inside_window(v, TEAL_WIN_B);
		m[3] = inside_window(v, PINK_WIN_A) || inside_window(v, PINK_WIN_B);
		return m;
	endfunction

	function automatic channel_t grey_level(rgb_t p);
		return channel_t'((p.green >> 1) + (p.red >> 2) + (p.blue >> 2));
	endfunction

	// edge beats fill, fill beats grey
	function automatic rgb_t overlay_pixel(rgb_t p, int col, ball_mask_t conf);
		channel_t grey;
		for (int c = 3; c >= 0; c--) begin
			if ((col == box_left[c] && box_left[c] != IMAGE_W - 1) ||
				(col == box_right[c] && box_right[c] != 0))
				return EDGE_COLOUR[c];
		end
		for (int c = 0; c < 4; c++) begin
			if (conf[c])
				return FILL_COLOUR[c];
		end
		grey = grey_level(p);
		return '{grey, grey, grey};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// stream and register drivers
	//////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		source_ready <= (($random(seed) & 3) != 0);
	end

	// values are stable from the falling edge up to the transfer edge
	always @(negedge clk) begin
		if (reset_n && source_valid && source_ready)
			out_q.push_back({source_data, source_sop, source_eop});
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display(">>> FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic send_beat(input beat_t b);
		logic accepted;
		sink_data <= b.pixel;
		sink_sop <= b.sop;
		sink_eop <= b.eop;
		sink_valid <= 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = sink_ready;
			@(posedge clk);
		end
	endtask

	task automatic reg_read(input logic [2:0] addr, output logic [31:0] data);
		s_chipselect <= 1'b1;
		s_read <= 1'b1;
		s_address <= addr;
		@(posedge clk);
		s_chipselect <= 1'b0;
		s_read <= 1'b0;
		@(negedge clk);
		data = s_readdata;
		@(posedge clk);
	endtask

	task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
		s_chipselect <= 1'b1;
		s_write <= 1'b1;
		s_address <= addr;
		s_writedata <= data;
		@(posedge clk);
		s_chipselect <= 1'b0;
		s_write <= 1'b0;
	endtask

	task automatic check_fifo_count(input int expected);
		logic [31:0] data;
		reg_read(REG_STATUS, data);
		check_value("s_readdata (REG_STATUS)", data, 32'(expected) << 8);
	endtask

	// writer starts one cycle after the eop advance, then one word per cycle
	task automatic wait_message_writer();
		repeat (MSG_WORDS + 3) @(posedge clk);
	endtask

	task automatic compare_outputs();
		while (out_q.size() < exp_q.size())
			@(posedge clk);
		for (int i = 0; i < exp_q.size(); i++) begin
			check_value("source_data", out_q[i].pixel, exp_q[i].pixel);
			check_value("source_sop", out_q[i].sop, exp_q[i].sop);
			check_value("source_eop", out_q[i].eop, exp_q[i].eop);
		end
		out_q.delete();
		exp_q.delete();
	endtask

	// random background that never matches, red and yellow runs in one row
	task automatic build_frame();
		rgb_t p;
		for (int i = 0; i < FRAME_PIX; i++) begin
			do
				p = rgb_t'($random(seed));
			while (colour_match(p) != '0);
			pkt_pix[i] = p;
		end
		for (int col = RED_START; col <= RED_END; col++)
			pkt_pix[RUN_ROW * IMAGE_W + col] = 24'hb43c00;
		for (int col = YELLOW_START; col <= YELLOW_END; col++)
			pkt_pix[RUN_ROW * IMAGE_W + col] = 24'hffe632;
	endtask

	task automatic send_packet(input logic video, input logic ovl, input int n_pix);
		beat_t b, e;
		ball_mask_t raw, conf;
		int col;
		mode <= ovl;
		b = '0;
		b.sop = 1'b1;
		b.pixel.blue = video ? 8'h00 : 8'h0f;
		for (int c = 0; c < 4; c++) begin
			run_len[c] = 0;
			cur_left[c] = IMAGE_W - 1;
			cur_right[c] = 0;
		end
		exp_q.push_back(b);
		send_beat(b);
		for (int i = 0; i < n_pix; i++) begin
			col = i % IMAGE_W;
			b.pixel = pkt_pix[i];
			b.sop = 1'b0;
			b.eop = (i == n_pix - 1);
			raw = colour_match(b.pixel);
			for (int c = 0; c < 4; c++) begin
				run_len[c] = raw[c] ? run_len[c] + 1 : 0;
				conf[c] = video && run_len[c] >= RUN_LEN;
				if (conf[c] && col < cur_left[c])
					cur_left[c] = col;
				if (conf[c] && col > cur_right[c])
					cur_right[c] = col;
			end
			e = b;
			if (ovl && video)
				e.pixel = overlay_pixel(b.pixel, col, conf);
			exp_q.push_back(e);
			send_beat(b);
		end
		sink_valid <= 1'b0;
		sink_eop <= 1'b0;
		if (video) begin
			box_left = cur_left;
			box_right = cur_right;
		end
		compare_outputs();
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic registers_after_reset();
		logic [31:0] data;
		reg_read(REG_ID, data);
		check_value("s_readdata (REG_ID)", data, 32'h1234eee2);
		check_fifo_count(0);
	endtask

	// frame 1 passes through and starts the first message
	task automatic passthrough_and_trigger();
		build_frame();
		send_packet(1'b1, 1'b0, FRAME_PIX);
		wait_message_writer();
		check_fifo_count(MSG_WORDS);
	endtask

	task automatic overlay_frame();
		build_frame();
		send_packet(1'b1, 1'b1, FRAME_PIX);
		wait_message_writer();
		check_fifo_count(MSG_WORDS);
	endtask

	// frames 3 to 6 run the interval counter down to zero
	task automatic interval_frames();
		for (int f = 3; f <= 6; f++) begin
			build_frame();
			send_packet(1'b1, 1'b0, FRAME_PIX);
			wait_message_writer();
			check_fifo_count(MSG_WORDS);
		end
	endtask

	// a red run in a control packet must not reach the boxes or the interval
	task automatic non_video_packet();
		for (int i = 0; i < NV_PIX; i++)
			pkt_pix[i] = 24'hb43c00;
		send_packet(1'b0, 1'b1, NV_PIX);
		wait_message_writer();
		check_fifo_count(MSG_WORDS);
		build_frame();
		send_packet(1'b1, 1'b1, FRAME_PIX);
		wait_message_writer();
		check_fifo_count(2 * MSG_WORDS);
	endtask

	task automatic message_contents_and_flush();
		logic [31:0] words [MSG_WORDS];
		logic [31:0] data;
		int lefts [4], rights [4];
		lefts = '{RED_START + RUN_LEN - 1, YELLOW_START + RUN_LEN - 1, IMAGE_W - 1, IMAGE_W - 1};
		rights = '{RED_END, YELLOW_END, 0, 0};
		// ascii RBB
		words[0] = 32'h00524242;
		for (int c = 0; c < 4; c++)
			words[c + 1] = (32'(c + 1) << 28) | (32'(lefts[c]) << 11) | 32'(rights[c]);
		for (int i = 0; i < MSG_WORDS; i++) begin
			reg_read(REG_MSG, data);
			check_value($sformatf("s_readdata (REG_MSG word %0d)", i), data, words[i]);
		end
		check_fifo_count(MSG_WORDS);
		reg_write(REG_STATUS, 32'(1) << STATUS_FLUSH_BIT);
		check_fifo_count(0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence and watchdog
	//////////////////////////////////////////////////////////////////////
	initial begin
		mode = 1'b0;
		sink_data = '0;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		source_ready = 1'b0;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		s_write = 1'b0;
		s_address = '0;
		s_writedata = '0;
		for (int c = 0; c < 4; c++) begin
			box_left[c] = IMAGE_W - 1;
			box_right[c] = 0;
		end
		wait (reset_n);
		@(posedge clk);
		registers_after_reset();
		passthrough_and_trigger();
		overlay_frame();
		interval_frames();
		non_video_packet();
		message_contents_and_flush();
		$display(">>> PASS");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: tests/tb_clock.sv
//////////////////////////////////////////////////////////////////////
// testbench clock and reset
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset_n
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// released on a rising edge after two cycles
	initial begin
		reset_n = 1'b0;
		repeat (2) @(posedge clk);
		reset_n <= 1'b1;
	end

endmodule
